// File: cpu.f
+incdir+tb
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/id_ex_reg.sv
hw/execute_stage.sv
hw/mem_arbiter.sv
hw/cpu_top.sv
tb/tb_cpu.sv

// File: run_sim.sh
#!/bin/sh
# build tb_cpu with Verilator, run it into a log and judge the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu \
	-f cpu.f -Mdir obj_dir -o tb_cpu
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_cpu > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
exit 0

// File: tb/cpu_model.svh
// cpu reference model: LCG, random program generator and instruction-set model
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

localparam int             BODY_LEN   = 28;
// random body, one store per register 1..31, then halt
localparam int             PROG_LEN   = BODY_LEN + 32;
localparam cpu_pkg::word_t DATA_BASE  = 32'h0000_0400;
localparam int             DATA_WORDS = 64;

cpu_pkg::word_t lcg_state = 32'h3bf703cc;
cpu_pkg::word_t prog [PROG_LEN];
cpu_pkg::word_t init_dmem [DATA_WORDS];
cpu_pkg::word_t model_dmem [DATA_WORDS];
cpu_pkg::word_t exp_store_addr [$];
cpu_pkg::word_t exp_store_data [$];

function automatic cpu_pkg::word_t lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// upper half only, the low bits of an LCG repeat quickly
function automatic int rand_below(input int n);
	cpu_pkg::word_t r;
	r = lcg_next();
	return int'({16'h0000, r[31:16]}) % n;
endfunction

function automatic cpu_pkg::regbits_t rand_reg();
	// mostly r0..r7 so that neighbours often depend on each other
	if (rand_below(4) == 0)
		return 5'(rand_below(32));
	return 5'(rand_below(8));
endfunction

function automatic void gen_program();
	cpu_pkg::funct_t   fn;
	cpu_pkg::regbits_t rs, rt, rd;
	logic [15:0]       imm, off;
	for (int i = 0; i < DATA_WORDS; i++)
		init_dmem[i] = lcg_next();
	for (int i = 0; i < BODY_LEN; i++) begin
		rs  = rand_reg();
		rt  = rand_reg();
		rd  = rand_reg();
		imm = 16'(rand_below(65536));
		// word offset from r0 into the data region
		off = 16'(DATA_BASE) + 16'(4 * rand_below(DATA_WORDS));
		case (rand_below(5))
			0:       fn = cpu_pkg::ADDU;
			1:       fn = cpu_pkg::SUBU;
			2:       fn = cpu_pkg::AND;
			3:       fn = cpu_pkg::OR;
			default: fn = cpu_pkg::SLT;
		endcase
		case (rand_below(10))
			0, 1, 2, 3: prog[i] = {cpu_pkg::RTYPE, rs, rt, rd, 5'd0, fn};
			4:          prog[i] = {cpu_pkg::ADDIU, rs, rt, imm};
			5:          prog[i] = {cpu_pkg::ORI, rs, rt, imm};
			6:          prog[i] = {cpu_pkg::LUI, 5'd0, rt, imm};
			7, 8:       prog[i] = {cpu_pkg::LW, 5'd0, rt, off};
			default:    prog[i] = {cpu_pkg::SW, 5'd0, rt, off};
		endcase
	end
	for (int r = 1; r < 32; r++)
		prog[BODY_LEN + r - 1] = {cpu_pkg::SW, 5'd0, 5'(r),
			16'(DATA_BASE) + 16'(4 * (r - 1))};
	prog[PROG_LEN - 1] = {cpu_pkg::HALT, 26'd0};
endfunction

// runs the program in order, MIPS field layout, and records every store
function automatic void run_model();
	cpu_pkg::word_t    regs [32];
	cpu_pkg::word_t    ins, a, b, sext, res;
	cpu_pkg::regbits_t dest;
	logic              wr;
	int                idx;
	for (int i = 0; i < 32; i++)
		regs[i] = '0;
	model_dmem = init_dmem;
	for (int pc = 0; pc < PROG_LEN; pc++) begin
		ins  = prog[pc];
		a    = regs[ins[25:21]];
		b    = regs[ins[20:16]];
		sext = {{16{ins[15]}}, ins[15:0]};
		idx  = int'((a + sext - DATA_BASE) >> 2);
		dest = ins[20:16];
		wr   = 1'b1;
		res  = '0;
		case (ins[31:26])
			cpu_pkg::RTYPE: begin
				dest = ins[15:11];
				case (ins[5:0])
					cpu_pkg::ADDU: res = a + b;
					cpu_pkg::SUBU: res = a - b;
					cpu_pkg::AND:  res = a & b;
					cpu_pkg::OR:   res = a | b;
					default:       res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				endcase
			end
			cpu_pkg::ADDIU: res = a + sext;
			cpu_pkg::ORI:   res = a | {16'h0000, ins[15:0]};
			cpu_pkg::LUI:   res = {ins[15:0], 16'h0000};
			cpu_pkg::LW:    res = model_dmem[idx];
			cpu_pkg::SW: begin
				wr = 1'b0;
				model_dmem[idx] = b;
				exp_store_addr.push_back(a + sext);
				exp_store_data.push_back(b);
			end
			default: wr = 1'b0;
		endcase
		if (wr && (dest != 5'd0))
			regs[dest] = res;
	end
endfunction

`endif

// File: tb/tb_cpu.sv
// testbench for cpu_top: random program, bus memory with random delays, model checks
`timescale 1ns/1ps

module tb_cpu;

	localparam cpu_pkg::word_t RESET_PC        = 32'h0000_0000;
	localparam int             MEM_WORDS       = 512;

	logic           CLK;
	logic           nRST;
	logic           mem_req;
	logic           mem_wen;
	cpu_pkg::word_t mem_addr;
	cpu_pkg::word_t mem_wdata;
	logic           mem_ack;
	cpu_pkg::word_t mem_rdata;
	logic           halted;

	cpu_pkg::word_t mem [MEM_WORDS];
	int             fetch_count;
	int             store_count;

	`include "cpu_model.svh"

	// roughly 40 cycles per instruction at worst, plus slack
	localparam int WATCHDOG_CYCLES = PROG_LEN * 40 + 400;

	cpu_top #(.RESET_PC(RESET_PC)) DUT (
		.CLK(CLK), .nRST(nRST),
		.mem_req(mem_req), .mem_wen(mem_wen), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata),
		.halted(halted)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input cpu_pkg::word_t expected,
		input cpu_pkg::word_t actual);
		if (actual !== expected)
			stop_run($sformatf("[ERROR] %0t ns %s expected %08h actual %08h",
				$time, name, expected, actual));
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			stop_run($sformatf("[ERROR] %0t ns %s expected %b actual %b",
				$time, name, expected, actual));
	endtask

	task automatic load_memory();
		// unused words get a pattern built from the full byte address
		for (int k = 0; k < MEM_WORDS; k++)
			mem[k] = cpu_pkg::word_t'(4 * k) * 32'h9e37_79b1;
		for (int k = 0; k < PROG_LEN; k++)
			mem[RESET_PC / 4 + k] = prog[k];
		for (int k = 0; k < DATA_WORDS; k++)
			mem[DATA_BASE / 4 + k] = init_dmem[k];
	endtask

	// fetches walk the program one word at a time from RESET_PC
	task automatic take_fetch(input cpu_pkg::word_t addr);
		if (fetch_count >= PROG_LEN)
			stop_run($sformatf("fetch from %08h after the HALT word was fetched", addr));
		check_word("mem_addr", RESET_PC + cpu_pkg::word_t'(4 * fetch_count), addr);
		fetch_count++;
	endtask

	task automatic take_store(input cpu_pkg::word_t addr, input cpu_pkg::word_t data);
		if (store_count >= exp_store_addr.size())
			stop_run($sformatf("unexpected extra store of %08h to %08h", data, addr));
		check_word("mem_addr", exp_store_addr[store_count], addr);
		check_word("mem_wdata", exp_store_data[store_count], data);
		mem[addr >> 2] = data;
		store_count++;
	endtask

	// bus memory: random 0..3 cycle wait, then ack until req drops
	initial begin
		int             delay;
		int             idx;
		cpu_pkg::word_t addr;
		cpu_pkg::word_t rdata;
		mem_ack   = 1'b0;
		mem_rdata = '0;
		forever begin
			@(negedge CLK);
			if (nRST && mem_req) begin
				delay = rand_below(4);
				repeat (delay)
					@(negedge CLK);
				addr  = mem_addr;
				idx   = int'(addr >> 2);
				rdata = '0;
				if (idx >= MEM_WORDS)
					stop_run($sformatf("bus access to %08h outside the memory", addr));
				if (mem_wen)
					take_store(addr, mem_wdata);
				else if (addr < DATA_BASE)
					take_fetch(addr);
				else if (idx >= DATA_BASE / 4 + DATA_WORDS)
					stop_run($sformatf("load from %08h outside the data region", addr));
				if (!mem_wen)
					rdata = mem[idx];
				@(posedge CLK);
				mem_ack   <= 1'b1;
				mem_rdata <= rdata;
				do begin
					@(negedge CLK);
				end while (mem_req);
				@(posedge CLK);
				mem_ack   <= 1'b0;
				mem_rdata <= '0;
			end
		end
	end

	// four-phase rule as seen on the external bus
	initial begin
		logic prev_req;
		prev_req = 1'b0;
		forever begin
			@(negedge CLK);
			if (nRST) begin
				if (prev_req && !mem_req && !mem_ack)
					stop_run("mem_req fell before mem_ack rose");
				if (!prev_req && mem_req && mem_ack)
					stop_run("mem_req rose while mem_ack was still high");
			end
			prev_req = mem_req;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		stop_run($sformatf("timeout, halted did not rise within %0d cycles",
			WATCHDOG_CYCLES));
	end

	initial begin
		nRST        = 1'b0;
		fetch_count = 0;
		store_count = 0;
		gen_program();
		run_model();
		load_memory();
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		check_flag("halted", 1'b0, halted);
		check_flag("mem_req", 1'b0, mem_req);
		@(posedge CLK);
		nRST <= 1'b1;
		// first cycle out of reset, nothing requested yet
		@(negedge CLK);
		check_flag("halted", 1'b0, halted);
		check_flag("mem_req", 1'b0, mem_req);

		while (halted !== 1'b1)
			@(negedge CLK);
		if (store_count != exp_store_addr.size())
			stop_run($sformatf("halted after %0d of %0d stores",
				store_count, exp_store_addr.size()));

		// a halted core stays quiet on the bus
		repeat (20) @(negedge CLK);
		check_flag("halted", 1'b1, halted);
		check_flag("mem_req", 1'b0, mem_req);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: hw/cpu_top.sv
// cpu top: fetch, decode, ID/EX, execute and the shared memory bus arbiter
`timescale 1ns/1ps

module cpu_top #(
	parameter cpu_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input  logic           CLK,
	input  logic           nRST,
	output logic           mem_req,
	output logic           mem_wen,
	output cpu_pkg::word_t mem_addr,
	output cpu_pkg::word_t mem_wdata,
	input  logic           mem_ack,
	input  cpu_pkg::word_t mem_rdata,
	output logic           halted
);

	// fetch side
	logic              fetch_req, fetch_ack;
	cpu_pkg::word_t    fetch_addr, fetch_rdata;
	logic              if_valid, if_take;
	cpu_pkg::word_t    if_instr;

	// decode to ID/EX
	logic              id_enable, id_flush;
	logic              d_wen, d_dren, d_dwen, d_halt;
	cpu_pkg::aluop_t   d_alu_op;
	cpu_pkg::alu_src_t d_alu_src;
	cpu_pkg::regbits_t d_rd;
	cpu_pkg::word_t    d_rdat1, d_rdat2, d_imm_ext;

	// ID/EX to execute
	logic              ex_wen, ex_dren, ex_dwen, ex_halt;
	cpu_pkg::aluop_t   ex_alu_op;
	cpu_pkg::alu_src_t ex_alu_src;
	cpu_pkg::regbits_t ex_rd;
	cpu_pkg::word_t    ex_rdat1, ex_rdat2, ex_imm_ext;

	// execute side
	logic              ex_busy, wb_wen;
	cpu_pkg::regbits_t wb_rd;
	cpu_pkg::word_t    wb_data;
	logic              data_req, data_ack, data_wen;
	cpu_pkg::word_t    data_addr, data_wdata, data_rdata;

	fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
		.CLK(CLK), .nRST(nRST), .if_take(if_take),
		.fetch_ack(fetch_ack), .fetch_rdata(fetch_rdata),
		.fetch_req(fetch_req), .fetch_addr(fetch_addr),
		.if_valid(if_valid), .if_instr(if_instr)
	);

	decode_stage u_decode (
		.CLK(CLK), .nRST(nRST), .if_valid(if_valid), .if_instr(if_instr),
		.ex_busy(ex_busy), .ex_wen(ex_wen), .ex_rd(ex_rd),
		.wb_wen(wb_wen), .wb_rd(wb_rd), .wb_data(wb_data),
		.if_take(if_take), .id_enable(id_enable), .id_flush(id_flush),
		.d_wen(d_wen), .d_dren(d_dren), .d_dwen(d_dwen), .d_halt(d_halt),
		.d_alu_op(d_alu_op), .d_alu_src(d_alu_src), .d_rd(d_rd),
		.d_rdat1(d_rdat1), .d_rdat2(d_rdat2), .d_imm_ext(d_imm_ext)
	);

	id_ex_reg u_id_ex (
		.CLK(CLK), .nRST(nRST), .enable(id_enable), .flush(id_flush),
		.d_wen(d_wen), .d_dren(d_dren), .d_dwen(d_dwen), .d_halt(d_halt),
		.d_alu_op(d_alu_op), .d_alu_src(d_alu_src), .d_rd(d_rd),
		.d_rdat1(d_rdat1), .d_rdat2(d_rdat2), .d_imm_ext(d_imm_ext),
		.ex_wen(ex_wen), .ex_dren(ex_dren), .ex_dwen(ex_dwen), .ex_halt(ex_halt),
		.ex_alu_op(ex_alu_op), .ex_alu_src(ex_alu_src), .ex_rd(ex_rd),
		.ex_rdat1(ex_rdat1), .ex_rdat2(ex_rdat2), .ex_imm_ext(ex_imm_ext)
	);

	execute_stage u_execute (
		.CLK(CLK), .nRST(nRST),
		.ex_wen(ex_wen), .ex_dren(ex_dren), .ex_dwen(ex_dwen), .ex_halt(ex_halt),
		.ex_alu_op(ex_alu_op), .ex_alu_src(ex_alu_src), .ex_rd(ex_rd),
		.ex_rdat1(ex_rdat1), .ex_rdat2(ex_rdat2), .ex_imm_ext(ex_imm_ext),
		.data_ack(data_ack), .data_rdata(data_rdata), .ex_busy(ex_busy),
		.data_req(data_req), .data_wen(data_wen), .data_addr(data_addr),
		.data_wdata(data_wdata), .wb_wen(wb_wen), .wb_rd(wb_rd),
		.wb_data(wb_data), .halted(halted)
	);

	mem_arbiter u_arbiter (
		.CLK(CLK), .nRST(nRST),
		.fetch_req(fetch_req), .fetch_addr(fetch_addr),
		.fetch_ack(fetch_ack), .fetch_rdata(fetch_rdata),
		.data_req(data_req), .data_wen(data_wen), .data_addr(data_addr),
		.data_wdata(data_wdata), .data_ack(data_ack), .data_rdata(data_rdata),
		.mem_req(mem_req), .mem_wen(mem_wen), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
	);

endmodule

// File: hw/mem_arbiter.sv
// memory arbiter: shares one four-phase bus between the data and fetch ports
`timescale 1ns/1ps

module mem_arbiter (
	input  logic           CLK,
	input  logic           nRST,
	input  logic           fetch_req,
	input  cpu_pkg::word_t fetch_addr,
	output logic           fetch_ack,
	output cpu_pkg::word_t fetch_rdata,
	input  logic           data_req,
	input  logic           data_wen,
	input  cpu_pkg::word_t data_addr,
	input  cpu_pkg::word_t data_wdata,
	output logic           data_ack,
	output cpu_pkg::word_t data_rdata,
	output logic           mem_req,
	output logic           mem_wen,
	output cpu_pkg::word_t mem_addr,
	output cpu_pkg::word_t mem_wdata,
	input  logic           mem_ack,
	input  cpu_pkg::word_t mem_rdata
);

	typedef enum logic [1:0] {GNT_IDLE, GNT_FETCH, GNT_DATA} grant_t;

	grant_t grant, grant_nxt;
	logic   bus_free;

	// owner has finished its handshake, or nobody owns the bus
	always_comb begin
		case (grant)
			GNT_FETCH: bus_free = !fetch_req && !mem_ack;
			GNT_DATA:  bus_free = !data_req && !mem_ack;
			default:   bus_free = !mem_ack;
		endcase
		grant_nxt = grant;
		if (bus_free) begin
			// data port wins a tie
			if (data_req)
				grant_nxt = GNT_DATA;
			else if (fetch_req)
				grant_nxt = GNT_FETCH;
			else
				grant_nxt = GNT_IDLE;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST)
			grant <= GNT_IDLE;
		else
			grant <= grant_nxt;
	end

	assign mem_req   = (grant == GNT_DATA)  ? data_req :
	                   (grant == GNT_FETCH) ? fetch_req : 1'b0;
	assign mem_wen   = (grant == GNT_DATA) && data_wen;
	assign mem_addr  = (grant == GNT_DATA) ? data_addr : fetch_addr;
	assign mem_wdata = data_wdata;

	assign fetch_ack   = (grant == GNT_FETCH) && mem_ack;
	assign fetch_rdata = (grant == GNT_FETCH) ? mem_rdata : '0;
	assign data_ack    = (grant == GNT_DATA) && mem_ack;
	assign data_rdata  = (grant == GNT_DATA) ? mem_rdata : '0;

	one_ack: assert property (@(posedge CLK) disable iff (!nRST)
		!(fetch_ack && data_ack));

endmodule

// File: hw/execute_stage.sv
// execute stage: ALU, load/store handshake and register write-back
`timescale 1ns/1ps

module execute_stage (
	input  logic              CLK,
	input  logic              nRST,
	input  logic              ex_wen,
	input  logic              ex_dren,
	input  logic              ex_dwen,
	input  logic              ex_halt,
	input  cpu_pkg::aluop_t   ex_alu_op,
	input  cpu_pkg::alu_src_t ex_alu_src,
	input  cpu_pkg::regbits_t ex_rd,
	input  cpu_pkg::word_t    ex_rdat1,
	input  cpu_pkg::word_t    ex_rdat2,
	input  cpu_pkg::word_t    ex_imm_ext,
	input  logic              data_ack,
	input  cpu_pkg::word_t    data_rdata,
	output logic              ex_busy,
	output logic              data_req,
	output logic              data_wen,
	output cpu_pkg::word_t    data_addr,
	output cpu_pkg::word_t    data_wdata,
	output logic              wb_wen,
	output cpu_pkg::regbits_t wb_rd,
	output cpu_pkg::word_t    wb_data,
	output logic              halted
);

	cpu_pkg::mem_fsm_t state, state_nxt;
	cpu_pkg::word_t    opb;
	cpu_pkg::word_t    alu_out;
	cpu_pkg::word_t    load_data;
	logic              mem_op;

	assign opb = (ex_alu_src == cpu_pkg::SEL_IMM) ? ex_imm_ext : ex_rdat2;

	always_comb begin
		case (ex_alu_op)
			cpu_pkg::ALU_SUB: alu_out = ex_rdat1 - opb;
			cpu_pkg::ALU_AND: alu_out = ex_rdat1 & opb;
			cpu_pkg::ALU_OR:  alu_out = ex_rdat1 | opb;
			cpu_pkg::ALU_SLT: alu_out = {31'd0, $signed(ex_rdat1) < $signed(opb)};
			cpu_pkg::ALU_LUI: alu_out = {opb[15:0], 16'h0000};
			default:          alu_out = ex_rdat1 + opb;
		endcase
	end

	assign mem_op = ex_dren || ex_dwen;
	// busy until the falling ack is seen
	assign ex_busy = mem_op && !((state == cpu_pkg::MEM_DROP) && !data_ack);

	always_comb begin
		state_nxt = state;
		case (state)
			cpu_pkg::MEM_IDLE: if (mem_op) state_nxt = cpu_pkg::MEM_REQ;
			cpu_pkg::MEM_REQ:  if (data_ack) state_nxt = cpu_pkg::MEM_DROP;
			cpu_pkg::MEM_DROP: if (!data_ack) state_nxt = cpu_pkg::MEM_IDLE;
			default:           state_nxt = cpu_pkg::MEM_IDLE;
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state  <= cpu_pkg::MEM_IDLE;
			halted <= 1'b0;
		end else begin
			state <= state_nxt;
			if (ex_halt && !ex_busy)
				halted <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if ((state == cpu_pkg::MEM_REQ) && data_ack)
			load_data <= data_rdata;
	end

	assign data_req   = (state == cpu_pkg::MEM_REQ);
	assign data_wen   = ex_dwen;
	assign data_addr  = alu_out;
	assign data_wdata = ex_rdat2;

	assign wb_wen  = ex_wen && !ex_busy;
	assign wb_rd   = ex_rd;
	assign wb_data = ex_dren ? load_data : alu_out;

	// decode must hold ID/EX for the whole request
	addr_stable: assert property (@(posedge CLK) disable iff (!nRST)
		data_req && $past(data_req) |-> $stable(data_addr) && $stable(data_wen));

endmodule

// File: hw/id_ex_reg.sv
// ID/EX pipeline register with hold, bubble insertion and reset to a no-op
`timescale 1ns/1ps

module id_ex_reg (
	input  logic              CLK,
	input  logic              nRST,
	input  logic              enable,
	input  logic              flush,
	input  logic              d_wen,
	input  logic              d_dren,
	input  logic              d_dwen,
	input  logic              d_halt,
	input  cpu_pkg::aluop_t   d_alu_op,
	input  cpu_pkg::alu_src_t d_alu_src,
	input  cpu_pkg::regbits_t d_rd,
	input  cpu_pkg::word_t    d_rdat1,
	input  cpu_pkg::word_t    d_rdat2,
	input  cpu_pkg::word_t    d_imm_ext,
	output logic              ex_wen,
	output logic              ex_dren,
	output logic              ex_dwen,
	output logic              ex_halt,
	output cpu_pkg::aluop_t   ex_alu_op,
	output cpu_pkg::alu_src_t ex_alu_src,
	output cpu_pkg::regbits_t ex_rd,
	output cpu_pkg::word_t    ex_rdat1,
	output cpu_pkg::word_t    ex_rdat2,
	output cpu_pkg::word_t    ex_imm_ext
);

	// control fields, flush takes priority over enable
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			ex_wen     <= 1'b0;
			ex_dren    <= 1'b0;
			ex_dwen    <= 1'b0;
			ex_halt    <= 1'b0;
			ex_alu_op  <= cpu_pkg::ALU_ADD;
			ex_alu_src <= cpu_pkg::SEL_REG_DATA;
			ex_rd      <= 5'd0;
		end else if (flush) begin
			ex_wen     <= 1'b0;
			ex_dren    <= 1'b0;
			ex_dwen    <= 1'b0;
			ex_halt    <= 1'b0;
			ex_alu_op  <= cpu_pkg::ALU_ADD;
			ex_alu_src <= cpu_pkg::SEL_REG_DATA;
			ex_rd      <= 5'd0;
		end else if (enable) begin
			ex_wen     <= d_wen;
			ex_dren    <= d_dren;
			ex_dwen    <= d_dwen;
			ex_halt    <= d_halt;
			ex_alu_op  <= d_alu_op;
			ex_alu_src <= d_alu_src;
			ex_rd      <= d_rd;
		end
	end

	// operands only matter behind a valid control word
	always_ff @(posedge CLK) begin
		if (enable && !flush) begin
			ex_rdat1   <= d_rdat1;
			ex_rdat2   <= d_rdat2;
			ex_imm_ext <= d_imm_ext;
		end
	end

endmodule

// File: hw/decode_stage.sv
// decode stage: instruction decoder, register file and RAW hazard stall control
`timescale 1ns/1ps

module decode_stage (
	input  logic              CLK,
	input  logic              nRST,
	input  logic              if_valid,
	input  cpu_pkg::word_t    if_instr,
	input  logic              ex_busy,
	input  logic              ex_wen,
	input  cpu_pkg::regbits_t ex_rd,
	input  logic              wb_wen,
	input  cpu_pkg::regbits_t wb_rd,
	input  cpu_pkg::word_t    wb_data,
	output logic              if_take,
	output logic              id_enable,
	output logic              id_flush,
	output logic              d_wen,
	output logic              d_dren,
	output logic              d_dwen,
	output logic              d_halt,
	output cpu_pkg::aluop_t   d_alu_op,
	output cpu_pkg::alu_src_t d_alu_src,
	output cpu_pkg::regbits_t d_rd,
	output cpu_pkg::word_t    d_rdat1,
	output cpu_pkg::word_t    d_rdat2,
	output cpu_pkg::word_t    d_imm_ext
);

	cpu_pkg::word_t    regs [32];
	cpu_pkg::opcode_t  opcode;
	cpu_pkg::funct_t   funct;
	cpu_pkg::regbits_t rs, rt, rd;
	logic [15:0]       imm16;
	logic              uses_rs, uses_rt;
	logic              hazard;

	assign opcode = if_instr[cpu_pkg::OP_MSB:cpu_pkg::OP_LSB];
	assign rs     = if_instr[cpu_pkg::RS_MSB:cpu_pkg::RS_LSB];
	assign rt     = if_instr[cpu_pkg::RT_MSB:cpu_pkg::RT_LSB];
	assign rd     = if_instr[cpu_pkg::RD_MSB:cpu_pkg::RD_LSB];
	assign funct  = if_instr[cpu_pkg::FUNCT_MSB:cpu_pkg::FUNCT_LSB];
	assign imm16  = if_instr[cpu_pkg::IMM_MSB:cpu_pkg::IMM_LSB];

	always_comb begin
		d_wen     = 1'b0;
		d_dren    = 1'b0;
		d_dwen    = 1'b0;
		d_halt    = 1'b0;
		d_alu_op  = cpu_pkg::ALU_ADD;
		d_alu_src = cpu_pkg::SEL_IMM;
		d_rd      = rt;
		d_imm_ext = {{16{imm16[15]}}, imm16};
		uses_rs   = 1'b0;
		uses_rt   = 1'b0;
		case (opcode)
			cpu_pkg::RTYPE: begin
				d_rd      = rd;
				d_alu_src = cpu_pkg::SEL_REG_DATA;
				uses_rs   = 1'b1;
				uses_rt   = 1'b1;
				d_wen     = 1'b1;
				case (funct)
					cpu_pkg::ADDU: d_alu_op = cpu_pkg::ALU_ADD;
					cpu_pkg::SUBU: d_alu_op = cpu_pkg::ALU_SUB;
					cpu_pkg::AND:  d_alu_op = cpu_pkg::ALU_AND;
					cpu_pkg::OR:   d_alu_op = cpu_pkg::ALU_OR;
					cpu_pkg::SLT:  d_alu_op = cpu_pkg::ALU_SLT;
					// unknown funct behaves as a no-op
					default:       d_wen    = 1'b0;
				endcase
			end
			cpu_pkg::ADDIU: begin
				d_wen   = 1'b1;
				uses_rs = 1'b1;
			end
			cpu_pkg::ORI: begin
				d_wen     = 1'b1;
				d_alu_op  = cpu_pkg::ALU_OR;
				d_imm_ext = {16'h0000, imm16};
				uses_rs   = 1'b1;
			end
			cpu_pkg::LUI: begin
				d_wen    = 1'b1;
				d_alu_op = cpu_pkg::ALU_LUI;
			end
			cpu_pkg::LW: begin
				d_wen   = 1'b1;
				d_dren  = 1'b1;
				uses_rs = 1'b1;
			end
			cpu_pkg::SW: begin
				d_dwen  = 1'b1;
				uses_rs = 1'b1;
				uses_rt = 1'b1;
			end
			cpu_pkg::HALT: d_halt = 1'b1;
			default: ;
		endcase
	end

	// register 0 is never written so it reads zero
	assign d_rdat1 = regs[rs];
	assign d_rdat2 = regs[rt];

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wb_wen && (wb_rd != 5'd0)) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// source still being produced by the instruction in ID/EX
	assign hazard = ex_wen && (ex_rd != 5'd0) &&
		((uses_rs && (rs == ex_rd)) || (uses_rt && (rt == ex_rd)));

	// a busy execute stage freezes ID/EX, so no bubble may overwrite it
	assign id_enable = !ex_busy;
	assign if_take   = if_valid && !ex_busy && !hazard;
	assign id_flush  = !ex_busy && (!if_valid || hazard);

	// instruction waiting behind a busy execute stage stays in the buffer
	no_take_busy: assert property (@(posedge CLK) disable iff (!nRST)
		ex_busy && if_valid |=> if_valid && $stable(if_instr));

endmodule

// File: hw/fetch_stage.sv
// fetch stage: program counter, instruction request FSM and one-entry IF/ID buffer
`timescale 1ns/1ps

module fetch_stage #(
	parameter cpu_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input  logic           CLK,
	input  logic           nRST,
	input  logic           if_take,
	input  logic           fetch_ack,
	input  cpu_pkg::word_t fetch_rdata,
	output logic           fetch_req,
	output cpu_pkg::word_t fetch_addr,
	output logic           if_valid,
	output cpu_pkg::word_t if_instr
);

	cpu_pkg::mem_fsm_t state, state_nxt;
	cpu_pkg::word_t    pc;
	cpu_pkg::word_t    buf_instr;
	logic              buf_valid;
	logic              halt_seen;
	logic              capture;

	assign capture    = (state == cpu_pkg::MEM_REQ) && fetch_ack;
	assign fetch_req  = (state == cpu_pkg::MEM_REQ);
	assign fetch_addr = pc;
	assign if_valid   = buf_valid;
	assign if_instr   = buf_instr;

	// request again as soon as the buffer is empty or being drained
	always_comb begin
		state_nxt = state;
		case (state)
			cpu_pkg::MEM_IDLE: begin
				if (!halt_seen && (!buf_valid || if_take))
					state_nxt = cpu_pkg::MEM_REQ;
			end
			cpu_pkg::MEM_REQ: begin
				if (fetch_ack)
					state_nxt = cpu_pkg::MEM_DROP;
			end
			cpu_pkg::MEM_DROP: begin
				if (!fetch_ack)
					state_nxt = cpu_pkg::MEM_IDLE;
			end
			default: state_nxt = cpu_pkg::MEM_IDLE;
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state     <= cpu_pkg::MEM_IDLE;
			pc        <= RESET_PC;
			buf_valid <= 1'b0;
			halt_seen <= 1'b0;
		end else begin
			state <= state_nxt;
			if (if_take)
				buf_valid <= 1'b0;
			if (capture) begin
				buf_valid <= 1'b1;
				pc        <= pc + 32'd4;
				// nothing past a halt gets fetched
				if (fetch_rdata[cpu_pkg::OP_MSB:cpu_pkg::OP_LSB] == cpu_pkg::HALT)
					halt_seen <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (capture)
			buf_instr <= fetch_rdata;
	end

	// req only drops once the memory has answered
	req_held: assert property (@(posedge CLK) disable iff (!nRST)
		$fell(fetch_req) |-> $past(fetch_ack));

endmodule

// File: hw/cpu_pkg.sv
// cpu types: word and field widths, opcodes, ALU operations and handshake FSM states
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  regbits_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;

	// primary opcodes
	localparam opcode_t RTYPE = 6'h00;
	localparam opcode_t ADDIU = 6'h09;
	localparam opcode_t ORI   = 6'h0d;
	localparam opcode_t LUI   = 6'h0f;
	localparam opcode_t LW    = 6'h23;
	localparam opcode_t SW    = 6'h2b;
	localparam opcode_t HALT  = 6'h3f;

	// r-type function codes
	localparam funct_t ADDU = 6'h21;
	localparam funct_t SUBU = 6'h23;
	localparam funct_t AND  = 6'h24;
	localparam funct_t OR   = 6'h25;
	localparam funct_t SLT  = 6'h2a;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_LUI} aluop_t;

	// second ALU operand
	typedef enum logic {SEL_REG_DATA, SEL_IMM} alu_src_t;

	// four-phase requester states
	typedef enum logic [1:0] {MEM_IDLE, MEM_REQ, MEM_DROP} mem_fsm_t;

	// instruction field positions
	localparam int OP_MSB    = 31;
	localparam int OP_LSB    = 26;
	localparam int RS_MSB    = 25;
	localparam int RS_LSB    = 21;
	localparam int RT_MSB    = 20;
	localparam int RT_LSB    = 16;
	localparam int RD_MSB    = 15;
	localparam int RD_LSB    = 11;
	localparam int FUNCT_MSB = 5;
	localparam int FUNCT_LSB = 0;
	localparam int IMM_MSB   = 15;
	localparam int IMM_LSB   = 0;

endpackage
